/* project.f */
+incdir+include
source/debug_pkg.sv
source/baud_tick_gen.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/program_loader.sv
source/state_dumper.sv
source/debug_controller.sv
source/debug_unit_top.sv
testbench/tb_uart_host.sv
testbench/tb_debug_unit.sv

/* testbench/tb_debug_unit.sv */
`include "debug_consts.svh"

module tb_debug_unit;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 10;
    localparam int BAUD_DIV   = 4;
    localparam int BIT_CLKS   = BAUD_DIV * `DBG_OVERSAMPLE;
    localparam int NUM_ROWS   = 10;
    localparam int MAX_SEND   = 16;
    localparam int MAX_RECV   = 128;
    localparam int MEM_DEPTH  = 2 ** `DBG_MEM_ADDR_W;

    logic                       clk;
    logic                       reset;
    logic                       uart_rx;
    logic                       uart_tx;
    debug_pkg::reg_file_t       registers;
    logic [`DBG_WORD_W-1:0]     mem_data;
    logic [`DBG_MEM_ADDR_W-1:0] mem_addr;
    debug_pkg::imem_write_t     imem_write;
    logic                       cpu_enable;
    logic                       step_mode;

    logic [`DBG_WORD_W-1:0] dmem [MEM_DEPTH];
    logic [`DBG_WORD_W-1:0] imem [MEM_DEPTH];

    // Command table of bytes sent by the host and bytes expected back
    logic [7:0] send_tab [NUM_ROWS][MAX_SEND];
    int         send_len [NUM_ROWS];
    logic [7:0] recv_tab [NUM_ROWS][MAX_RECV];
    int         recv_len [NUM_ROWS];
    logic       step_exp;
    int         total_bytes;
    logic       table_ready;

    always #(CLK_PERIOD / 2) clk = ~clk;

    debug_unit_top #(
        .BAUD_DIV(BAUD_DIV)
    ) dut (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_uart_rx   (uart_rx),
        .i_registers (registers),
        .i_mem_data  (mem_data),
        .o_uart_tx   (uart_tx),
        .o_mem_addr  (mem_addr),
        .o_imem_write(imem_write),
        .o_cpu_enable(cpu_enable),
        .o_step_mode (step_mode)
    );

    tb_uart_host #(
        .BAUD_DIV(BAUD_DIV)
    ) host (
        .i_clk     (clk),
        .i_line_in (uart_tx),
        .o_line_out(uart_rx)
    );

    assign mem_data = dmem[mem_addr]; // Combinational data memory

    always @(negedge clk) begin
        if (imem_write.en) begin
            imem[imem_write.addr] = imem_write.data;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic set_row(input int r, input logic [7:0] cmd, input int n_args);
        send_tab[r][0] = cmd;
        for (int i = 1; i <= n_args; i++) begin
            send_tab[r][i] = 8'($urandom);
        end
        send_len[r] = 1 + n_args;
        recv_len[r] = 0;
    endtask

    task automatic expect_word(input int r, input int slot, input logic [31:0] word);
        for (int b = 0; b < 4; b++) begin
            recv_tab[r][4 * slot + b] = word[8 * b +: 8]; // LSB first on the line
        end
        recv_len[r] = 4 * (slot + 1);
    endtask

    task automatic build_table();
        set_row(0, `DBG_CMD_DUMP_REGS, 0);
        for (int i = 0; i < `DBG_NUM_REGS; i++) begin
            expect_word(0, i, registers[i]);
        end
        set_row(1, `DBG_CMD_READ_MEM, 1);
        send_tab[1][1] = 8'h15;
        expect_word(1, 0, dmem[6'h15]);
        set_row(2, `DBG_CMD_READ_MEM, 1);
        send_tab[2][1] = 8'hEA;
        expect_word(2, 0, dmem[6'h2A]); // Only the low 6 address bits count
        set_row(3, `DBG_CMD_LOAD_PROG, 13);
        send_tab[3][1] = 8'd3;
        set_row(4, `DBG_CMD_MODE_STEP, 0);
        set_row(5, `DBG_CMD_STEP, 0);
        set_row(6, `DBG_CMD_STEP, 0);
        set_row(7, `DBG_CMD_LOAD_PROG, 5); // Load while in step mode
        send_tab[7][1] = 8'd1;
        set_row(8, `DBG_CMD_MODE_CONT, 0);
        set_row(9, `DBG_CMD_STEP, 0);
        total_bytes = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_bytes += send_len[r] + recv_len[r];
        end
    endtask

    task automatic send_row(input int r);
        for (int i = 0; i < send_len[r]; i++) begin
            host.send_byte(send_tab[r][i]);
        end
    endtask

    task automatic collect_row(input int r);
        logic [7:0] data;
        logic       stop_ok;
        for (int i = 0; i < recv_len[r]; i++) begin
            host.recv_byte(data, stop_ok);
            check_value("o_uart_tx stop bit", stop_ok, 1'b1);
            check_value($sformatf("o_uart_tx byte %0d of row %0d", i, r), data,
                        recv_tab[r][i]);
        end
    endtask

    task automatic watch_enable(input int r, input logic step_before);
        int highs;
        int writes;
        highs  = 0;
        writes = 0;
        if (send_tab[r][0] == `DBG_CMD_LOAD_PROG) begin
            repeat (10 * BIT_CLKS) @(negedge clk); // Load command has been taken
            while (writes < (send_len[r] - 2) / 4) begin
                @(negedge clk);
                check_value("o_cpu_enable", cpu_enable, 1'b0);
                if (imem_write.en) begin
                    writes++;
                end
            end
            @(negedge clk);
            check_value("o_cpu_enable", cpu_enable, !step_before);
        end else if (send_tab[r][0] == `DBG_CMD_STEP) begin
            repeat (11 * BIT_CLKS) begin
                @(negedge clk);
                if (cpu_enable) begin
                    highs++;
                end
            end
            check_value("o_cpu_enable high cycles", highs, step_before ? 1 : 11 * BIT_CLKS);
        end
    endtask

    task automatic run_row(input int r);
        logic        step_before;
        logic [31:0] word;
        step_before = step_exp;
        if (send_tab[r][0] == `DBG_CMD_MODE_STEP) begin
            step_exp = 1'b1;
        end else if (send_tab[r][0] == `DBG_CMD_MODE_CONT) begin
            step_exp = 1'b0;
        end
        fork
            send_row(r);
            collect_row(r);
            watch_enable(r, step_before);
        join
        repeat (2) @(negedge clk);
        check_value("o_step_mode", step_mode, step_exp);
        check_value("o_cpu_enable", cpu_enable, !step_exp);
        if (send_tab[r][0] == `DBG_CMD_READ_MEM) begin
            check_value("o_mem_addr", mem_addr, send_tab[r][1] % MEM_DEPTH);
        end
        if (send_tab[r][0] == `DBG_CMD_LOAD_PROG) begin
            for (int k = 0; k < send_tab[r][1]; k++) begin
                word = {send_tab[r][4 * k + 5], send_tab[r][4 * k + 4],
                        send_tab[r][4 * k + 3], send_tab[r][4 * k + 2]};
                check_value($sformatf("imem[%0d]", k), imem[k], word);
            end
        end
    endtask

    initial begin
        table_ready = 1'b0;
        wait (table_ready);
        #(CLK_PERIOD * (total_bytes * 10 * BIT_CLKS * 2 + 200));
        $display("Timeout: the DUT did not work through the command table in time");
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        void'($urandom(32'h0e53e601));
        clk      = 1'b0;
        reset    = 1'b1;
        step_exp = 1'b0;
        for (int i = 0; i < `DBG_NUM_REGS; i++) begin
            registers[i] = $urandom;
        end
        for (int a = 0; a < MEM_DEPTH; a++) begin
            dmem[a] = 32'h9E37_79B9 * (a + 1); // Differs for every address
            imem[a] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("o_cpu_enable", cpu_enable, 1'b1);
        check_value("o_step_mode", step_mode, 1'b0);
        check_value("o_uart_tx", uart_tx, 1'b1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* testbench/tb_uart_host.sv */
`include "debug_consts.svh"

module tb_uart_host #(
    parameter int BAUD_DIV = 4
) (
    input  logic i_clk,
    input  logic i_line_in,  // Serial line coming from the DUT
    output logic o_line_out  // Serial line going into the DUT
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT_CLKS = BAUD_DIV * `DBG_OVERSAMPLE;

    initial begin
        o_line_out = 1'b1; // Idle line
    end

    // 8N1 frame with each bit held for exactly BIT_CLKS clocks
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clk);
            o_line_out <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge i_clk);
        end
    endtask

    // Returns once the middle of the stop bit has been sampled
    task automatic recv_byte(output logic [7:0] data, output logic stop_ok);
        @(negedge i_clk);
        while (i_line_in !== 1'b0) begin
            @(negedge i_clk);
        end
        repeat (BIT_CLKS / 2) @(negedge i_clk); // Middle of the start bit
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge i_clk);
            data[i] = i_line_in; // LSB first
        end
        repeat (BIT_CLKS) @(negedge i_clk);
        stop_ok = i_line_in;
    endtask

endmodule

/* source/debug_unit_top.sv */
`include "debug_consts.svh"

module debug_unit_top #(
    parameter int BAUD_DIV = `DBG_BAUD_DIV_DEFAULT
) (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_uart_rx,
    input  debug_pkg::reg_file_t       i_registers,
    input  logic [`DBG_WORD_W-1:0]     i_mem_data,
    output logic                       o_uart_tx,
    output logic [`DBG_MEM_ADDR_W-1:0] o_mem_addr,
    output debug_pkg::imem_write_t     o_imem_write,
    output logic                       o_cpu_enable,
    output logic                       o_step_mode
);

    logic                    tick;
    debug_pkg::byte_strobe_t rx_byte;
    logic                    load_start;
    logic                    load_done;
    logic                    dump_start;
    debug_pkg::dump_kind_t   dump_kind;
    logic                    dump_done;
    logic                    tx_start;
    logic [7:0]              tx_data;
    logic                    tx_busy;

    baud_tick_gen #(
        .BAUD_DIV(BAUD_DIV)
    ) u_baud (
        .i_clk  (i_clk),
        .i_reset(i_reset),
        .o_tick (tick)
    );

    uart_receiver u_rx (
        .i_clk  (i_clk),
        .i_reset(i_reset),
        .i_tick (tick),
        .i_rx   (i_uart_rx),
        .o_byte (rx_byte)
    );

    uart_transmitter u_tx (
        .i_clk  (i_clk),
        .i_reset(i_reset),
        .i_tick (tick),
        .i_start(tx_start),
        .i_data (tx_data),
        .o_busy (tx_busy),
        .o_tx   (o_uart_tx)
    );

    program_loader u_loader (
        .i_clk  (i_clk),
        .i_reset(i_reset),
        .i_start(load_start),
        .i_rx   (rx_byte),
        .o_write(o_imem_write),
        .o_done (load_done)
    );

    state_dumper u_dumper (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_start    (dump_start),
        .i_kind     (dump_kind),
        .i_rx       (rx_byte),
        .i_registers(i_registers),
        .i_mem_data (i_mem_data),
        .i_tx_busy  (tx_busy),
        .o_mem_addr (o_mem_addr),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data),
        .o_done     (dump_done)
    );

    debug_controller u_ctrl (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rx        (rx_byte),
        .i_load_done (load_done),
        .i_dump_done (dump_done),
        .o_load_start(load_start),
        .o_dump_start(dump_start),
        .o_dump_kind (dump_kind),
        .o_step_mode (o_step_mode),
        .o_cpu_enable(o_cpu_enable)
    );

endmodule

/* source/debug_controller.sv */
`include "debug_consts.svh"

module debug_controller (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  debug_pkg::byte_strobe_t i_rx,
    input  logic                    i_load_done,
    input  logic                    i_dump_done,
    output logic                    o_load_start,
    output logic                    o_dump_start,
    output debug_pkg::dump_kind_t   o_dump_kind,
    output logic                    o_step_mode,
    output logic                    o_cpu_enable
);

    typedef enum logic [1:0] {CT_IDLE, CT_LOAD, CT_DUMP} ct_state_t;

    ct_state_t             state;
    debug_pkg::dump_kind_t kind_q;
    logic                  step_mode_q;
    logic                  saved_mode_q;
    logic                  step_pulse_q;
    logic                  load_start_q;
    logic                  dump_start_q;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state        <= CT_IDLE;
            kind_q       <= debug_pkg::REGS;
            step_mode_q  <= 1'b0;
            saved_mode_q <= 1'b0;
            step_pulse_q <= 1'b0;
            load_start_q <= 1'b0;
            dump_start_q <= 1'b0;
        end else begin
            step_pulse_q <= 1'b0;
            load_start_q <= 1'b0;
            dump_start_q <= 1'b0;
            case (state)
                CT_IDLE: begin
                    if (i_rx.valid) begin
                        case (i_rx.data)
                            `DBG_CMD_DUMP_REGS: begin
                                kind_q       <= debug_pkg::REGS;
                                dump_start_q <= 1'b1;
                                state        <= CT_DUMP;
                            end
                            `DBG_CMD_READ_MEM: begin
                                kind_q       <= debug_pkg::MEM; // Dumper takes the address byte
                                dump_start_q <= 1'b1;
                                state        <= CT_DUMP;
                            end
                            `DBG_CMD_LOAD_PROG: begin
                                saved_mode_q <= step_mode_q;
                                step_mode_q  <= 1'b0;
                                load_start_q <= 1'b1;
                                state        <= CT_LOAD;
                            end
                            `DBG_CMD_MODE_CONT: step_mode_q <= 1'b0;
                            `DBG_CMD_MODE_STEP: step_mode_q <= 1'b1;
                            `DBG_CMD_STEP:      step_pulse_q <= step_mode_q; // No-op when running
                            default: ;
                        endcase
                    end
                end
                CT_LOAD: begin
                    if (i_load_done) begin
                        step_mode_q <= saved_mode_q;
                        state       <= CT_IDLE;
                    end
                end
                default: begin
                    if (i_dump_done) begin
                        state <= CT_IDLE;
                    end
                end
            endcase
        end
    end

    assign o_load_start = load_start_q;
    assign o_dump_start = dump_start_q;
    assign o_dump_kind  = kind_q;
    assign o_step_mode  = step_mode_q;

    // Core is frozen while instruction memory is rewritten
    assign o_cpu_enable = (state != CT_LOAD) && (!step_mode_q || step_pulse_q);

endmodule

/* source/state_dumper.sv */
`include "debug_consts.svh"

module state_dumper (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_start,
    input  debug_pkg::dump_kind_t      i_kind,
    input  debug_pkg::byte_strobe_t    i_rx,
    input  debug_pkg::reg_file_t       i_registers,
    input  logic [`DBG_WORD_W-1:0]     i_mem_data,
    input  logic                       i_tx_busy,
    output logic [`DBG_MEM_ADDR_W-1:0] o_mem_addr,
    output logic                       o_tx_start,
    output logic [7:0]                 o_tx_data,
    output logic                       o_done
);

    localparam int WORD_BYTES = `DBG_WORD_W / 8;
    localparam int SEL_W      = $clog2(WORD_BYTES);
    localparam int REG_IDX_W  = $clog2(`DBG_NUM_REGS);
    localparam int CNT_W      = REG_IDX_W + SEL_W;
    localparam logic [CNT_W-1:0] REGS_LAST = CNT_W'(`DBG_NUM_REGS * WORD_BYTES - 1);
    localparam logic [CNT_W-1:0] MEM_LAST  = CNT_W'(WORD_BYTES - 1);

    typedef enum logic [1:0] {DP_IDLE, DP_ADDR, DP_SEND, DP_DRAIN} dp_state_t;

    dp_state_t                  state;
    debug_pkg::dump_kind_t      kind_q;
    logic [CNT_W-1:0]           byte_cnt;
    logic [CNT_W-1:0]           last_cnt;
    logic [`DBG_MEM_ADDR_W-1:0] addr_q;
    logic [`DBG_WORD_W-1:0]     word;

    assign last_cnt = (kind_q == debug_pkg::REGS) ? REGS_LAST : MEM_LAST;

    // Upper count bits pick the register, lower bits the byte
    assign word = (kind_q == debug_pkg::REGS) ? i_registers[byte_cnt[CNT_W-1:SEL_W]]
                                              : i_mem_data;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= DP_IDLE;
            kind_q   <= debug_pkg::REGS;
            byte_cnt <= '0;
            addr_q   <= '0;
        end else begin
            case (state)
                DP_IDLE: begin
                    if (i_start) begin
                        kind_q   <= i_kind;
                        byte_cnt <= '0;
                        state    <= (i_kind == debug_pkg::MEM) ? DP_ADDR : DP_SEND;
                    end
                end
                DP_ADDR: begin
                    if (i_rx.valid) begin
                        addr_q <= i_rx.data[`DBG_MEM_ADDR_W-1:0];
                        state  <= DP_SEND;
                    end
                end
                DP_SEND: begin
                    if (!i_tx_busy) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == last_cnt) begin
                            state <= DP_DRAIN;
                        end
                    end
                end
                default: begin
                    if (!i_tx_busy) begin
                        state <= DP_IDLE; // Last stop bit is out
                    end
                end
            endcase
        end
    end

    assign o_mem_addr = addr_q;
    assign o_tx_start = (state == DP_SEND) && !i_tx_busy;
    assign o_tx_data  = word[byte_cnt[SEL_W-1:0] * 8 +: 8];
    assign o_done     = (state == DP_DRAIN) && !i_tx_busy;

endmodule

/* source/program_loader.sv */
`include "debug_consts.svh"

module program_loader (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_start,
    input  debug_pkg::byte_strobe_t i_rx,
    output debug_pkg::imem_write_t  o_write,
    output logic                    o_done
);

    typedef enum logic [1:0] {LD_IDLE, LD_COUNT, LD_WORDS} ld_state_t;

    ld_state_t                  state;
    logic [7:0]                 count_q;
    logic [7:0]                 word_cnt;
    logic [1:0]                 byte_idx;
    logic                       wr_en_q;
    logic                       done_q;
    logic [`DBG_WORD_W-1:0]     word_q;
    logic [`DBG_MEM_ADDR_W-1:0] wr_addr_q;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= LD_IDLE;
            count_q  <= '0;
            word_cnt <= '0;
            byte_idx <= '0;
            wr_en_q  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
            case (state)
                LD_IDLE: begin
                    if (i_start) begin
                        state <= LD_COUNT;
                    end
                end
                LD_COUNT: begin
                    if (i_rx.valid) begin
                        count_q  <= i_rx.data; // Number of words to follow
                        word_cnt <= '0;
                        byte_idx <= '0;
                        if (i_rx.data == 8'd0) begin
                            done_q <= 1'b1;
                            state  <= LD_IDLE;
                        end else begin
                            state <= LD_WORDS;
                        end
                    end
                end
                default: begin
                    if (i_rx.valid) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            wr_en_q  <= 1'b1;
                            word_cnt <= word_cnt + 1'b1;
                            if (word_cnt == count_q - 8'd1) begin
                                done_q <= 1'b1; // Same cycle as the last write
                                state  <= LD_IDLE;
                            end
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == LD_WORDS && i_rx.valid) begin
            word_q <= {i_rx.data, word_q[`DBG_WORD_W-1:8]}; // Little-endian assembly
            if (byte_idx == 2'd3) begin
                wr_addr_q <= word_cnt[`DBG_MEM_ADDR_W-1:0];
            end
        end
    end

    assign o_write.en   = wr_en_q;
    assign o_write.addr = wr_addr_q;
    assign o_write.data = word_q;
    assign o_done       = done_q;

endmodule

/* source/uart_transmitter.sv */
`include "debug_consts.svh"

module uart_transmitter (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_tick,
    input  logic       i_start,
    input  logic [7:0] i_data,
    output logic       o_busy,
    output logic       o_tx
);

    localparam int TICK_W = $clog2(`DBG_OVERSAMPLE);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`DBG_OVERSAMPLE - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        shift_q;
    logic              bit_end;

    assign bit_end = i_tick && (tick_cnt == LAST_TICK);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (state == TX_IDLE) begin
                tick_cnt <= '0;
                bit_cnt  <= '0;
                if (i_start) begin
                    state <= TX_START;
                end
            end else if (i_tick) begin
                tick_cnt <= tick_cnt + 1'b1; // Wraps after 16 ticks
                if (bit_end) begin
                    case (state)
                        TX_START: state <= TX_DATA;
                        TX_DATA: begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= TX_STOP;
                            end
                        end
                        default: state <= TX_IDLE;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_start) begin
            shift_q <= i_data;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign o_busy = (state != TX_IDLE);
    assign o_tx   = (state == TX_START) ? 1'b0 :
                    (state == TX_DATA)  ? shift_q[0] : 1'b1;

endmodule

/* source/uart_receiver.sv */
`include "debug_consts.svh"

module uart_receiver (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_tick,
    input  logic                    i_rx,
    output debug_pkg::byte_strobe_t o_byte
);

    localparam int TICK_W = $clog2(`DBG_OVERSAMPLE);
    localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(`DBG_OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`DBG_OVERSAMPLE - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t         state;
    logic [1:0]        sync_q;
    logic              rx_s;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        shift_q;
    logic              valid_q;

    assign rx_s = sync_q[1];

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            sync_q <= 2'b11; // Line idles high
        end else begin
            sync_q <= {sync_q[0], i_rx};
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx_s) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (i_tick) begin
                        if (tick_cnt == MID_TICK) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_s ? RX_IDLE : RX_DATA; // Glitch rejection
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (i_tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            bit_cnt  <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= RX_STOP;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (i_tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            valid_q <= rx_s; // Framing error drops the byte
                            state   <= RX_IDLE;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && i_tick && tick_cnt == LAST_TICK) begin
            shift_q <= {rx_s, shift_q[7:1]}; // LSB arrives first
        end
    end

    assign o_byte.valid = valid_q;
    assign o_byte.data  = shift_q;

endmodule

/* source/baud_tick_gen.sv */
`include "debug_consts.svh"

module baud_tick_gen #(
    parameter int BAUD_DIV = `DBG_BAUD_DIV_DEFAULT
) (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick
);

    localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(BAUD_DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            cnt <= '0;
        end else if (cnt == LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_tick = (cnt == LAST);

endmodule

/* source/debug_pkg.sv */
`include "debug_consts.svh"

package debug_pkg;

    typedef struct packed {
        logic       valid; // High for one clock per byte
        logic [7:0] data;
    } byte_strobe_t;

    typedef struct packed {
        logic                       en;
        logic [`DBG_MEM_ADDR_W-1:0] addr;
        logic [`DBG_WORD_W-1:0]     data;
    } imem_write_t;

    // Element 0 is register 0
    typedef logic [`DBG_NUM_REGS-1:0][`DBG_WORD_W-1:0] reg_file_t;

    typedef enum logic {
        REGS,
        MEM
    } dump_kind_t;

endpackage

/* include/debug_consts.svh */
`ifndef DEBUG_CONSTS_SVH
`define DEBUG_CONSTS_SVH

// Host command bytes
`define DBG_CMD_DUMP_REGS 8'h01
`define DBG_CMD_READ_MEM  8'h06
`define DBG_CMD_LOAD_PROG 8'h07
`define DBG_CMD_MODE_CONT 8'h08
`define DBG_CMD_MODE_STEP 8'h09
`define DBG_CMD_STEP      8'h0A

// Processor geometry
`define DBG_WORD_W     32
`define DBG_NUM_REGS   32
`define DBG_MEM_ADDR_W 6

// Serial line
`define DBG_OVERSAMPLE       16
`define DBG_BAUD_DIV_DEFAULT 326 // 50 MHz clock at 9600 baud

`endif
